// File: rtl/fx2_bus_pkg.sv
`default_nettype none

// Types and codes that describe the FX2 slave FIFO bus itself
package fx2_bus_pkg;

    // One byte on the 8-bit FX2 FIFO data bus
    typedef logic [7:0] byte_t;

    // The FIFOADR pins select one of the four FX2 endpoint FIFOs
    typedef logic [1:0] endpoint_t;

    // FIFO address codes for the two host-to-device endpoints in use
    // EP6 and EP8 would take codes 2 and 3 but are not serviced here
    localparam endpoint_t EP2_ADDR = 2'd0;
    localparam endpoint_t EP4_ADDR = 2'd1;

endpackage

`default_nettype wire

// File: rtl/packet_pkg.sv
`default_nettype none

// Types and constants that describe the packet format carried on EP2 and EP4
package packet_pkg;

    // Every packet opens with this marker byte
    localparam logic [7:0] HEADER_BYTE = 8'hFF;

    // Payload byte count, sent upper byte first
    typedef logic [15:0] length_t;

    // EP2 packets select one of the DAC tracking FIFO write ports
    localparam int NUM_DAC_PORTS = 4;
    typedef logic [$clog2(NUM_DAC_PORTS)-1:0] port_index_t;

    // EP4 packets carry a command identifier for the decoder
    typedef logic [7:0] command_id_t;

    // Command ID presented to the decoder while no command has arrived
    localparam command_id_t COMMAND_NOP = 8'h00;

    // Parser position within a packet
    // One state per header byte, then the payload until the count is reached
    typedef enum logic [2:0] {
        PACKET_WAITING      = 3'd0,
        PACKET_ID           = 3'd1,
        PACKET_LENGTH_UPPER = 3'd2,
        PACKET_LENGTH_LOWER = 3'd3,
        PACKET_PAYLOAD      = 3'd4
    } packet_state_t;

endpackage

`default_nettype wire

// File: rtl/packet_parser.sv
`default_nettype none

// Packet parser for one host-to-device endpoint
// It follows the header and payload of the packet on its endpoint one consumed byte at a time
// Nothing changes in a cycle without byte_strobe, so a packet can be left half read
// while the other endpoint is serviced and picked up again later
module packet_parser
    import fx2_bus_pkg::*;
    import packet_pkg::*;
#(
    // Type of the ID byte field, a DAC port index for EP2 or a command ID for EP4
    parameter type id_t = command_id_t
) (
    input  wire logic    usb_ifclk,
    input  wire logic    reset,
    input  wire byte_t   byte_in,
    input  wire logic    byte_strobe,
    output logic         in_payload,
    output logic         payload_strobe,
    output logic         packet_end,
    output id_t          pkt_id,
    output length_t      pkt_length
);

    packet_state_t state;

    // Number of payload bytes already consumed in the current packet
    length_t byte_count;

    // Count after the byte in this cycle has been taken
    length_t next_count;

    // Full length as it would read once the lower length byte is stored
    length_t header_length;

    assign next_count    = byte_count + length_t'(1);
    assign header_length = {pkt_length[15:8], byte_in};

    assign in_payload     = (state == PACKET_PAYLOAD);
    assign payload_strobe = byte_strobe && in_payload;

    // Packet end is flagged in the same cycle as the byte that causes it
    // so that the arbiter can switch endpoints at the following edge
    always_comb begin
        packet_end = 1'b0;
        if (byte_strobe) begin
            case (state)
                // A stray byte outside a packet is consumed and dropped
                PACKET_WAITING: begin
                    packet_end = (byte_in != HEADER_BYTE);
                end
                // A packet with no payload is complete after its length field
                PACKET_LENGTH_LOWER: begin
                    packet_end = (header_length == '0);
                end
                // Last payload byte when the count reaches the length
                PACKET_PAYLOAD: begin
                    packet_end = (next_count == pkt_length);
                end
                default: begin
                    packet_end = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            state      <= PACKET_WAITING;
            pkt_id     <= id_t'(COMMAND_NOP);
            pkt_length <= '0;
            byte_count <= '0;
        end else if (byte_strobe) begin
            case (state)
                PACKET_WAITING: begin
                    // Only the marker byte opens a packet
                    if (byte_in == HEADER_BYTE) begin
                        state <= PACKET_ID;
                    end
                end
                PACKET_ID: begin
                    // EP2 keeps only the low bits that name a DAC port
                    pkt_id <= id_t'(byte_in);
                    state  <= PACKET_LENGTH_UPPER;
                end
                PACKET_LENGTH_UPPER: begin
                    pkt_length[15:8] <= byte_in;
                    state            <= PACKET_LENGTH_LOWER;
                end
                PACKET_LENGTH_LOWER: begin
                    pkt_length[7:0] <= byte_in;
                    byte_count      <= '0;
                    // An empty packet goes straight back to looking for a header
                    if (packet_end) begin
                        state <= PACKET_WAITING;
                    end else begin
                        state <= PACKET_PAYLOAD;
                    end
                end
                PACKET_PAYLOAD: begin
                    byte_count <= next_count;
                    if (packet_end) begin
                        state <= PACKET_WAITING;
                    end
                end
                default: begin
                    state <= PACKET_WAITING;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/endpoint_arbiter.sv
`default_nettype none

// Endpoint arbiter for the two receive endpoints
// It alternates the FX2 FIFO address between EP2 and EP4, drives the read strobe
// and steers the consumed bytes to the DAC write ports or to the command decoder
module endpoint_arbiter
    import fx2_bus_pkg::*;
    import packet_pkg::*;
(
    input  wire logic         usb_ifclk,
    input  wire logic         reset,
    input  wire byte_t        usb_data_out,
    input  wire logic         usb_ep2_empty,
    input  wire logic         usb_ep4_empty,
    input  wire logic         cmd_in_read,
    input  wire logic         ep2_in_payload,
    input  wire logic         ep2_payload_strobe,
    input  wire logic         ep2_packet_end,
    input  wire port_index_t  ep2_pkt_id,
    input  wire logic         ep4_in_payload,
    input  wire logic         ep4_packet_end,
    input  wire command_id_t  ep4_pkt_id,
    input  wire length_t      ep4_pkt_length,
    output endpoint_t         usb_addr,
    output logic              usb_slrd,
    output logic              ep2_byte_strobe,
    output logic              ep4_byte_strobe,
    output byte_t             fifo_data,
    output logic [NUM_DAC_PORTS-1:0] fifo_write,
    output command_id_t       cmd_in_id,
    output length_t           cmd_in_length,
    output byte_t             cmd_in_data,
    output logic              cmd_in_ready
);

    // Endpoint currently addressed on the FX2 bus
    endpoint_t sel;

    // Low for the first cycle after reset while the address settles at the FX2
    logic sel_valid;

    logic sel_empty;
    logic sel_end;
    logic ep4_hold;
    logic read_en;
    logic [NUM_DAC_PORTS-1:0] port_mask;

    assign usb_addr = sel;

    // Flags of whichever endpoint is addressed
    assign sel_empty = (sel == EP4_ADDR) ? usb_ep4_empty : usb_ep2_empty;
    assign sel_end   = (sel == EP4_ADDR) ? ep4_packet_end : ep2_packet_end;

    // The decoder stalls the EP4 payload by dropping cmd_in_read
    assign ep4_hold = (sel == EP4_ADDR) && ep4_in_payload && !cmd_in_read;

    // A byte is taken only from a FIFO that holds one
    assign read_en  = sel_valid && !sel_empty && !ep4_hold;
    assign usb_slrd = !read_en;

    // Each parser sees only the bytes read from its own endpoint
    assign ep2_byte_strobe = read_en && (sel == EP2_ADDR);
    assign ep4_byte_strobe = read_en && (sel == EP4_ADDR);

    // Move to the other endpoint once the current one runs dry or its packet is over
    // A parser left mid-packet keeps its state until it is selected again
    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            sel       <= EP2_ADDR;
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= 1'b1;
            if (sel_empty || sel_end) begin
                sel <= (sel == EP2_ADDR) ? EP4_ADDR : EP2_ADDR;
            end
        end
    end

    // Port decode is meaningful only after the EP2 index byte has been parsed
    always_comb begin
        port_mask = '0;
        if (ep2_in_payload) begin
            port_mask[ep2_pkt_id] = 1'b1;
        end
    end

    // All DAC FIFOs share the data bus and one write strobe fires per payload byte
    assign fifo_data  = usb_data_out;
    assign fifo_write = ep2_payload_strobe ? port_mask : '0;

    // The decoder sees the EP4 header for as long as the payload is on offer
    assign cmd_in_id     = ep4_pkt_id;
    assign cmd_in_length = ep4_pkt_length;
    assign cmd_in_data   = usb_data_out;
    assign cmd_in_ready  = (sel == EP4_ADDR) && ep4_in_payload;

endmodule

`default_nettype wire

// File: rtl/fx2_interface.sv
`default_nettype none

// Receive side of the FX2 slave FIFO glue
// EP2 data packets feed the DAC tracking FIFOs and EP4 command packets feed the decoder
module fx2_interface
    import fx2_bus_pkg::*;
    import packet_pkg::*;
(
    input  wire logic         usb_ifclk,
    input  wire logic         reset,
    input  wire byte_t        usb_data_out,
    input  wire logic         usb_ep2_empty,
    input  wire logic         usb_ep4_empty,
    input  wire logic         cmd_in_read,
    output endpoint_t         usb_addr,
    output logic              usb_slrd,
    output logic              usb_sloe,
    output byte_t             fifo_data,
    output logic [NUM_DAC_PORTS-1:0] fifo_write,
    output command_id_t       cmd_in_id,
    output length_t           cmd_in_length,
    output byte_t             cmd_in_data,
    output logic              cmd_in_ready
);

    logic        ep2_byte_strobe;
    logic        ep2_in_payload;
    logic        ep2_payload_strobe;
    logic        ep2_packet_end;
    port_index_t ep2_pkt_id;

    logic        ep4_byte_strobe;
    logic        ep4_in_payload;
    logic        ep4_packet_end;
    command_id_t ep4_pkt_id;
    length_t     ep4_pkt_length;

    // The FX2 drives its data bus at all times
    assign usb_sloe = 1'b0;

    // EP2 parser keeps only the DAC port index from the ID byte
    // Its length is tracked internally and not needed outside
    packet_parser #(.id_t(port_index_t)) ep2_parser (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .byte_in        (usb_data_out),
        .byte_strobe    (ep2_byte_strobe),
        .in_payload     (ep2_in_payload),
        .payload_strobe (ep2_payload_strobe),
        .packet_end     (ep2_packet_end),
        .pkt_id         (ep2_pkt_id),
        .pkt_length     ()
    );

    // EP4 payload transfers follow the decoder handshake instead of the payload strobe
    packet_parser #(.id_t(command_id_t)) ep4_parser (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .byte_in        (usb_data_out),
        .byte_strobe    (ep4_byte_strobe),
        .in_payload     (ep4_in_payload),
        .payload_strobe (),
        .packet_end     (ep4_packet_end),
        .pkt_id         (ep4_pkt_id),
        .pkt_length     (ep4_pkt_length)
    );

    endpoint_arbiter endpoint_arbiter_inst (
        .usb_ifclk          (usb_ifclk),
        .reset              (reset),
        .usb_data_out       (usb_data_out),
        .usb_ep2_empty      (usb_ep2_empty),
        .usb_ep4_empty      (usb_ep4_empty),
        .cmd_in_read        (cmd_in_read),
        .ep2_in_payload     (ep2_in_payload),
        .ep2_payload_strobe (ep2_payload_strobe),
        .ep2_packet_end     (ep2_packet_end),
        .ep2_pkt_id         (ep2_pkt_id),
        .ep4_in_payload     (ep4_in_payload),
        .ep4_packet_end     (ep4_packet_end),
        .ep4_pkt_id         (ep4_pkt_id),
        .ep4_pkt_length     (ep4_pkt_length),
        .usb_addr           (usb_addr),
        .usb_slrd           (usb_slrd),
        .ep2_byte_strobe    (ep2_byte_strobe),
        .ep4_byte_strobe    (ep4_byte_strobe),
        .fifo_data          (fifo_data),
        .fifo_write         (fifo_write),
        .cmd_in_id          (cmd_in_id),
        .cmd_in_length      (cmd_in_length),
        .cmd_in_data        (cmd_in_data),
        .cmd_in_ready       (cmd_in_ready)
    );

endmodule

`default_nettype wire

// File: tb/fx2_interface_checker.sv
`default_nettype none

// Bus rules for the top-level ports of the FX2 receive glue
module fx2_interface_checker
    import fx2_bus_pkg::*;
    import packet_pkg::*;
(
    input wire logic                     usb_ifclk,
    input wire logic                     reset,
    input wire endpoint_t                usb_addr,
    input wire logic                     usb_slrd,
    input wire logic                     usb_ep2_empty,
    input wire logic                     usb_ep4_empty,
    input wire logic [NUM_DAC_PORTS-1:0] fifo_write,
    input wire logic                     cmd_in_ready
);

    // Only one DAC port is written per payload byte
    a_write_onehot: assert property (@(posedge usb_ifclk) disable iff (reset)
        $onehot0(fifo_write)) else $error("fifo_write has more than one bit set");

    // The FX2 must never be read from an empty FIFO
    a_read_not_empty: assert property (@(posedge usb_ifclk) disable iff (reset)
        !usb_slrd |-> !((usb_addr == EP4_ADDR) ? usb_ep4_empty : usb_ep2_empty))
        else $error("usb_slrd asserted on an empty FIFO");

    // EP2 payload and EP4 payload cannot be on the bus at once
    a_exclusive: assert property (@(posedge usb_ifclk) disable iff (reset)
        !(cmd_in_ready && (fifo_write != '0)))
        else $error("cmd_in_ready and fifo_write active together");

    // From the second reset cycle on every output is idle
    a_reset_idle: assert property (@(posedge usb_ifclk)
        (reset && $past(reset)) |-> (usb_slrd && (fifo_write == '0) && !cmd_in_ready))
        else $error("Outputs active during reset");

endmodule

bind fx2_interface fx2_interface_checker fx2_interface_checker_inst (
    .usb_ifclk     (usb_ifclk),
    .reset         (reset),
    .usb_addr      (usb_addr),
    .usb_slrd      (usb_slrd),
    .usb_ep2_empty (usb_ep2_empty),
    .usb_ep4_empty (usb_ep4_empty),
    .fifo_write    (fifo_write),
    .cmd_in_ready  (cmd_in_ready)
);

`default_nettype wire

// File: tb/fx2_interface_tb.sv
`default_nettype none

module fx2_interface_tb
    import fx2_bus_pkg::*;
    import packet_pkg::*;
;

    logic                     usb_ifclk;
    logic                     reset;
    byte_t                    usb_data_out;
    logic                     usb_ep2_empty;
    logic                     usb_ep4_empty;
    logic                     cmd_in_read;
    endpoint_t                usb_addr;
    logic                     usb_slrd;
    logic                     usb_sloe;
    byte_t                    fifo_data;
    logic [NUM_DAC_PORTS-1:0] fifo_write;
    command_id_t              cmd_in_id;
    length_t                  cmd_in_length;
    byte_t                    cmd_in_data;
    logic                     cmd_in_ready;

    // FX2 endpoint FIFO contents and the byte each one presents
    byte_t ep2_q[$];
    byte_t ep4_q[$];
    byte_t ep2_head;
    byte_t ep4_head;

    // Packet being assembled by a test before it is loaded
    byte_t pkt_bytes[$];

    // Scoreboards for DAC writes and decoder transfers
    port_index_t exp_port[$];
    byte_t       exp_dac[$];
    byte_t       exp_cmd[$];
    command_id_t exp_cmd_id;
    length_t     exp_cmd_len;

    string  test_name;
    integer seed;
    int     error_count;
    int     dac_writes;
    int     total_bytes;
    int     cycle_count;

    fx2_interface fx2_interface_inst (
        .usb_ifclk     (usb_ifclk),
        .reset         (reset),
        .usb_data_out  (usb_data_out),
        .usb_ep2_empty (usb_ep2_empty),
        .usb_ep4_empty (usb_ep4_empty),
        .cmd_in_read   (cmd_in_read),
        .usb_addr      (usb_addr),
        .usb_slrd      (usb_slrd),
        .usb_sloe      (usb_sloe),
        .fifo_data     (fifo_data),
        .fifo_write    (fifo_write),
        .cmd_in_id     (cmd_in_id),
        .cmd_in_length (cmd_in_length),
        .cmd_in_data   (cmd_in_data),
        .cmd_in_ready  (cmd_in_ready)
    );

    initial begin
        usb_ifclk = 1'b0;
        forever #50 usb_ifclk = ~usb_ifclk;
    end

    // The FX2 puts the head of the addressed FIFO on the bus
    assign usb_data_out = (usb_addr == EP4_ADDR) ? ep4_head : ep2_head;

    // A read strobe low at the edge consumes the head, flags follow the new fill
    always @(posedge usb_ifclk) begin
        if (usb_slrd == 1'b0) begin
            if (usb_addr == EP4_ADDR) begin
                void'(ep4_q.pop_front());
            end else begin
                void'(ep2_q.pop_front());
            end
        end
        usb_ep2_empty <= (ep2_q.size() == 0);
        usb_ep4_empty <= (ep4_q.size() == 0);
        ep2_head      <= (ep2_q.size() != 0) ? ep2_q[0] : 8'h00;
        ep4_head      <= (ep4_q.size() != 0) ? ep4_q[0] : 8'h00;
    end

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_port(input string name, input port_index_t exp, input port_index_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected port %0d, actual port %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_command(input string name, input command_id_t exp,
                                 input command_id_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected command 0x%h, actual 0x%h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_length(input string name, input length_t exp, input length_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_endpoint(input string name, input endpoint_t exp,
                                  input endpoint_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected endpoint %0d, actual endpoint %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            error_count++;
        end
    endtask

    function automatic port_index_t write_port(input logic [NUM_DAC_PORTS-1:0] strobes);
        port_index_t idx;
        idx = '0;
        for (int i = 0; i < NUM_DAC_PORTS; i++) begin
            if (strobes[i]) begin
                idx = port_index_t'(i);
            end
        end
        return idx;
    endfunction

    // Consumer side monitor, sampled at the edge where the transfer takes place
    always @(posedge usb_ifclk) begin
        if (!reset && fifo_write != '0) begin
            dac_writes++;
            if (exp_port.size() == 0) begin
                $display("%s: DAC write to port %0d that no packet asked for",
                         test_name, write_port(fifo_write));
                error_count++;
            end else begin
                check_port(test_name, exp_port.pop_front(), write_port(fifo_write));
                check_byte(test_name, exp_dac.pop_front(), fifo_data);
            end
        end
        if (!reset && cmd_in_ready && cmd_in_read && !usb_slrd) begin
            if (exp_cmd.size() == 0) begin
                $display("%s: command byte transferred that no packet asked for", test_name);
                error_count++;
            end else begin
                check_command(test_name, exp_cmd_id, cmd_in_id);
                check_length(test_name, exp_cmd_len, cmd_in_length);
                check_byte(test_name, exp_cmd.pop_front(), cmd_in_data);
            end
        end
    end

    // Header plus n random payload bytes
    task automatic stage_packet(input byte_t id, input int n);
        pkt_bytes.delete();
        pkt_bytes.push_back(HEADER_BYTE);
        pkt_bytes.push_back(id);
        pkt_bytes.push_back(byte_t'(n >> 8));
        pkt_bytes.push_back(byte_t'(n));
        for (int i = 0; i < n; i++) begin
            pkt_bytes.push_back(byte_t'($random(seed)));
        end
    endtask

    // Copy part of the staged packet into one FX2 FIFO between clock edges
    task automatic load_bytes(input endpoint_t ep, input int first, input int count);
        @(negedge usb_ifclk);
        for (int i = first; i < first + count; i++) begin
            if (ep == EP4_ADDR) begin
                ep4_q.push_back(pkt_bytes[i]);
            end else begin
                ep2_q.push_back(pkt_bytes[i]);
            end
        end
        total_bytes += count;
    endtask

    task automatic expect_dac(input port_index_t port);
        for (int i = 4; i < pkt_bytes.size(); i++) begin
            exp_port.push_back(port);
            exp_dac.push_back(pkt_bytes[i]);
        end
    endtask

    task automatic expect_cmd();
        exp_cmd_id  = pkt_bytes[1];
        exp_cmd_len = {pkt_bytes[2], pkt_bytes[3]};
        for (int i = 4; i < pkt_bytes.size(); i++) begin
            exp_cmd.push_back(pkt_bytes[i]);
        end
    endtask

    task automatic wait_drained();
        while (exp_dac.size() != 0 || exp_cmd.size() != 0) begin
            @(negedge usb_ifclk);
        end
    endtask

    task automatic test_dac_ports();
        int n;
        for (int k = 0; k < NUM_DAC_PORTS; k++) begin
            test_name = $sformatf("dac_port_%0d", k);
            n = 5 + ($random(seed) & 15);
            // Upper ID bits are set to show that only the low bits pick the port
            stage_packet(byte_t'(8'h40 + k), n);
            expect_dac(port_index_t'(k));
            load_bytes(EP2_ADDR, 0, pkt_bytes.size());
            wait_drained();
        end
    endtask

    task automatic test_command();
        test_name = "command";
        stage_packet(8'h5A, 12);
        expect_cmd();
        load_bytes(EP4_ADDR, 0, pkt_bytes.size());
        wait_drained();
        check_flag(test_name, 1'b0, cmd_in_ready);
        check_command(test_name, 8'h5A, cmd_in_id);
    endtask

    task automatic test_backpressure();
        int held;
        test_name = "backpressure";
        @(posedge usb_ifclk);
        cmd_in_read <= 1'b0;
        stage_packet(8'hC3, 10);
        expect_cmd();
        load_bytes(EP4_ADDR, 0, pkt_bytes.size());
        while (!cmd_in_ready) begin
            @(negedge usb_ifclk);
        end
        // While the decoder holds off, EP4 stays selected and its FIFO is left alone
        held = ep4_q.size();
        repeat (8) begin
            @(negedge usb_ifclk);
            check_flag(test_name, 1'b1, cmd_in_ready);
            check_flag(test_name, 1'b1, usb_slrd);
        end
        if (ep4_q.size() != held) begin
            $display("%s: bytes were read while the decoder held off the read", test_name);
            error_count++;
        end
        @(posedge usb_ifclk);
        cmd_in_read <= 1'b1;
        wait_drained();
    endtask

    task automatic test_junk_and_empty();
        int writes_before;
        test_name = "junk_bytes";
        pkt_bytes.delete();
        pkt_bytes.push_back(8'h12);
        pkt_bytes.push_back(8'h00);
        pkt_bytes.push_back(8'hFE);
        load_bytes(EP2_ADDR, 0, 3);
        stage_packet(8'h02, 6);
        expect_dac(port_index_t'(2));
        load_bytes(EP2_ADDR, 0, pkt_bytes.size());
        wait_drained();
        // Zero length packet must leave the DAC ports untouched
        test_name = "zero_length";
        writes_before = dac_writes;
        stage_packet(8'h01, 0);
        load_bytes(EP2_ADDR, 0, pkt_bytes.size());
        // The packet after it must start from its own header byte
        stage_packet(8'h01, 3);
        expect_dac(port_index_t'(1));
        load_bytes(EP2_ADDR, 0, pkt_bytes.size());
        wait_drained();
        repeat (6) @(negedge usb_ifclk);
        check_length(test_name, length_t'(writes_before + 3), length_t'(dac_writes));
    endtask

    task automatic test_interleave();
        byte_t ep2_pkt[$];
        test_name = "interleave";
        stage_packet(8'h03, 14);
        expect_dac(port_index_t'(3));
        ep2_pkt = pkt_bytes;
        load_bytes(EP2_ADDR, 0, 9);
        while (ep2_q.size() != 0) begin
            @(negedge usb_ifclk);
        end
        // EP2 is left mid payload while a command goes through
        stage_packet(8'h77, 7);
        expect_cmd();
        load_bytes(EP4_ADDR, 0, pkt_bytes.size());
        while (exp_cmd.size() != 0) begin
            @(negedge usb_ifclk);
        end
        pkt_bytes = ep2_pkt;
        load_bytes(EP2_ADDR, 9, pkt_bytes.size() - 9);
        wait_drained();
    endtask

    // Run limit grows with the bytes queued so far
    initial begin
        cycle_count = 0;
        @(posedge usb_ifclk);
        while (cycle_count <= total_bytes * 4 + 400) begin
            @(posedge usb_ifclk);
            cycle_count++;
        end
        $display("Timeout: the DUT did not finish the queued traffic in %0d cycles", cycle_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed          = 89;
        error_count   = 0;
        dac_writes    = 0;
        total_bytes   = 0;
        test_name     = "reset";
        reset         = 1'b1;
        usb_ep2_empty = 1'b1;
        usb_ep4_empty = 1'b1;
        cmd_in_read   = 1'b1;
        ep2_head      = 8'h00;
        ep4_head      = 8'h00;
        repeat (16) @(posedge usb_ifclk);
        reset <= 1'b0;
        @(negedge usb_ifclk);
        check_command("reset", COMMAND_NOP, cmd_in_id);
        check_length("reset", '0, cmd_in_length);
        check_endpoint("reset", EP2_ADDR, usb_addr);
        check_flag("reset", 1'b1, usb_slrd);
        check_flag("reset", 1'b0, cmd_in_ready);
        check_flag("reset", 1'b0, usb_sloe);
        test_dac_ports();
        test_command();
        test_backpressure();
        test_junk_and_empty();
        test_interleave();
        repeat (4) @(negedge usb_ifclk);
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fx2_glue.f
rtl/fx2_bus_pkg.sv
rtl/packet_pkg.sv
rtl/packet_parser.sv
rtl/endpoint_arbiter.sv
rtl/fx2_interface.sv
tb/fx2_interface_checker.sv
tb/fx2_interface_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the fx2_glue simulation with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f fx2_glue.f \
    --top-module fx2_interface_tb \
    -Mdir obj_dir \
    -o fx2_interface_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fx2_interface_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log
if [ $? -ne 0 ]; then
    echo "Pass message not found in sim.log"
    exit 1
fi

exit 0
